// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes of the fetch datapath
	////////////////////////////////////////////////////////////////////////////

	// Byte address space of the program counter
	localparam int pc_width = 12;
	// Word addressing into the instruction RAM
	localparam int imem_addr_width = 10;
	localparam int imem_depth = 1024;
	localparam int word_width = 32;
	// Debug index reaches the first 32 words only
	localparam int debug_addr_width = 5;
	// UART bit period in bus cycles
	localparam int clks_per_bit = 16;
	// Sequential step in bytes
	localparam int pc_step = 4;

	////////////////////////////////////////////////////////////////////////////
	// Bundles passed between the fetch blocks
	////////////////////////////////////////////////////////////////////////////

	// Control from the core
	typedef struct packed {
		logic                pc_en;
		logic                debug;
		logic                branch;
		logic                jalr;
		logic [pc_width-1:0] branch_offset;
	} fetch_ctrl_t;

	// Word write from the UART loader
	typedef struct packed {
		logic                       en;
		logic [imem_addr_width-1:0] addr;
		logic [word_width-1:0]      data;
	} imem_write_t;

	// Fetch read request with the pc riding along
	typedef struct packed {
		logic                       en;
		logic [imem_addr_width-1:0] addr;
		logic [pc_width-1:0]        pc;
	} imem_read_t;

	// Instruction together with the address it came from
	typedef struct packed {
		logic [pc_width-1:0]   pc;
		logic [word_width-1:0] ins;
	} fetch_out_t;

	// UART receiver states
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

endpackage

// ==== hw/pc_sequencer.sv ====
`timescale 1ns/1ps

module pc_sequencer (
	input  logic                   bus,
	input  logic                   reset,
	input  fetch_pkg::fetch_ctrl_t ctrl,
	input  logic                   loading,
	output fetch_pkg::imem_read_t  rd
);
	import fetch_pkg::*;

	logic [pc_width-1:0] pc;
	logic [pc_width-1:0] next_pc;
	logic [pc_width-1:0] seq_pc;
	logic [pc_width-1:0] branch_pc;
	logic                step_en;
	logic                offset_used;

	////////////////////////////////////////////////////////////////////////////
	// Next address selection
	////////////////////////////////////////////////////////////////////////////

	// Core advances only when enabled and not in debug
	assign step_en = ctrl.pc_en && !ctrl.debug;

	// All sums wrap at pc_width
	assign seq_pc    = pc + pc_width'(pc_step);
	assign branch_pc = pc + ctrl.branch_offset;

	// Jump register target beats branch which beats step
	always_comb begin
		if (ctrl.jalr) begin
			next_pc = ctrl.branch_offset;
		end else if (ctrl.branch) begin
			next_pc = branch_pc;
		end else begin
			next_pc = seq_pc;
		end
	end

	// PC register
	always_ff @(posedge bus) begin
		if (reset || loading) begin
			// Held at zero while a new program streams in
			pc <= '0;
		end else if (step_en) begin
			pc <= next_pc;
		end
	end

	// Read request toward the RAM
	assign rd.en   = step_en;
	assign rd.addr = pc[pc_width-1:2];
	assign rd.pc   = pc;

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Offset actually feeds the next pc this cycle
	assign offset_used = step_en && (ctrl.jalr || ctrl.branch);

	// Aligned pc and aligned offsets keep the pc aligned
	a_pc_aligned : assert property (@(posedge bus) disable iff (reset)
		(pc[1:0] == 2'b00 && !(offset_used && ctrl.branch_offset[1:0] != 2'b00))
		|=> pc[1:0] == 2'b00)
		else $error("pc lost word alignment");

	// Loader activity parks the pc at zero on the next cycle
	a_pc_cleared : assert property (@(posedge bus) loading |=> pc == '0)
		else $error("pc not cleared while loading");

endmodule

// ==== hw/uart_word_loader.sv ====
`timescale 1ns/1ps

module uart_word_loader (
	input  logic                   bus,
	input  logic                   reset,
	input  logic                   prog,
	input  logic                   rx,
	output fetch_pkg::imem_write_t wr,
	output logic                   loading
);
	import fetch_pkg::*;

	logic                            rx_meta;
	logic                            rx_sync;
	rx_state_t                       state;
	logic [$clog2(clks_per_bit)-1:0] clk_cnt;
	logic [2:0]                      bit_idx;
	logic [7:0]                      rx_byte;
	logic                            half_bit;
	logic                            full_bit;
	logic                            stop_ok;
	logic                            prog_q;
	logic                            prog_rise;
	logic [1:0]                      byte_cnt;
	logic [word_width-1:0]           word_q;
	logic [imem_addr_width-1:0]      addr_q;
	logic                            wr_en_q;

	////////////////////////////////////////////////////////////////////////////
	// Serial receiver
	////////////////////////////////////////////////////////////////////////////

	// Two flop synchronizer on a line that idles high
	always_ff @(posedge bus) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// Mid start bit and every full period after it
	assign half_bit = int'(clk_cnt) == clks_per_bit / 2 - 1;
	assign full_bit = int'(clk_cnt) == clks_per_bit - 1;
	// Good stop bit completes the byte
	assign stop_ok  = (state == rx_stop) && full_bit && rx_sync;

	always_ff @(posedge bus) begin
		if (reset) begin
			state   <= rx_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (!rx_sync) state <= rx_start;
				end
				rx_start: begin
					if (half_bit) begin
						clk_cnt <= '0;
						// Glitch shorter than half a bit goes back to idle
						state   <= rx_sync ? rx_idle : rx_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_data: begin
					if (full_bit) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) state <= rx_stop;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_stop: begin
					// Low stop bit just drops the byte
					if (full_bit) begin
						clk_cnt <= '0;
						state   <= rx_idle;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// LSB first shift
	always_ff @(posedge bus) begin
		if (state == rx_data && full_bit) rx_byte <= {rx_sync, rx_byte[7:1]};
	end

	////////////////////////////////////////////////////////////////////////////
	// Word assembly and write address
	////////////////////////////////////////////////////////////////////////////

	assign prog_rise = prog && !prog_q;

	always_ff @(posedge bus) begin
		if (reset) begin
			prog_q   <= 1'b0;
			loading  <= 1'b0;
			byte_cnt <= '0;
			addr_q   <= '0;
			wr_en_q  <= 1'b0;
		end else begin
			prog_q  <= prog;
			wr_en_q <= 1'b0;
			if (prog_rise) loading <= 1'b1;
			else if (!prog) loading <= 1'b0;
			if (prog_rise) begin
				// New program starts at word zero
				byte_cnt <= '0;
				addr_q   <= '0;
			end else begin
				if (wr_en_q) addr_q <= addr_q + 1'b1;
				if (stop_ok && loading && prog) begin
					byte_cnt <= byte_cnt + 1'b1;
					// Fourth byte closes the word
					if (byte_cnt == 2'd3) wr_en_q <= 1'b1;
				end
			end
		end
	end

	// Little endian so the first byte ends up in the low lane
	always_ff @(posedge bus) begin
		if (stop_ok && loading) word_q <= {rx_byte, word_q[word_width-1:8]};
	end

	assign wr.en   = wr_en_q;
	assign wr.addr = addr_q;
	assign wr.data = word_q;

	// One pulse per word
	a_wr_single : assert property (@(posedge bus) disable iff (reset) wr.en |=> !wr.en)
		else $error("write strobe held for two cycles");

	a_wr_loading : assert property (@(posedge bus) disable iff (reset) wr.en |-> loading)
		else $error("write issued outside programming mode");

endmodule

// ==== hw/imem_controller.sv ====
`timescale 1ns/1ps

module imem_controller (
	input  logic                                   bus,
	input  logic                                   reset,
	input  logic                                   prog,
	input  logic [fetch_pkg::debug_addr_width-1:0] debug_index,
	input  fetch_pkg::imem_write_t                 wr,
	input  fetch_pkg::imem_read_t                  rd,
	output fetch_pkg::fetch_out_t                  fetched
);
	import fetch_pkg::*;

	logic [word_width-1:0]      mem [imem_depth];
	logic                       dbg_grant;
	logic                       rd_grant;
	logic [imem_addr_width-1:0] dbg_addr;
	logic [pc_width-1:0]        dbg_pc;
	logic [imem_addr_width-1:0] rd_addr;
	logic [pc_width-1:0]        rd_pc;

	////////////////////////////////////////////////////////////////////////////
	// Arbitration
	////////////////////////////////////////////////////////////////////////////

	// Priority is write over debug over fetch
	assign dbg_grant = !wr.en && prog;
	assign rd_grant  = !wr.en && !prog && rd.en;

	// Debug index zero extended into a word address
	assign dbg_addr = imem_addr_width'(debug_index);
	// Byte address of the debug word
	assign dbg_pc   = pc_width'({debug_index, 2'b00});

	// Single read port shared by debug and fetch
	always_comb begin
		if (dbg_grant) begin
			rd_addr = dbg_addr;
			rd_pc   = dbg_pc;
		end else begin
			rd_addr = rd.addr;
			rd_pc   = rd.pc;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	// Instruction RAM written by the loader
	always_ff @(posedge bus) begin
		if (wr.en) mem[wr.addr] <= wr.data;
	end

	// Registered read, one cycle latency
	always_ff @(posedge bus) begin
		if (reset) begin
			fetched <= '0;
		end else if (dbg_grant || rd_grant) begin
			fetched.pc  <= rd_pc;
			fetched.ins <= mem[rd_addr];
		end
	end

	// No read is granted during a write so fetched stays put
	a_write_blocks_read : assert property (@(posedge bus) disable iff (reset)
		wr.en |=> $stable(fetched))
		else $error("read granted in a write cycle");

endmodule

// ==== hw/fetch_reprogrammable_top.sv ====
`timescale 1ns/1ps

module fetch_reprogrammable_top (
	input  logic                                   bus,
	input  logic                                   reset,
	input  fetch_pkg::fetch_ctrl_t                 ctrl,
	input  logic                                   prog,
	input  logic [fetch_pkg::debug_addr_width-1:0] debug_index,
	input  logic                                   rx,
	output fetch_pkg::fetch_out_t                  fetched,
	output logic                                   loading
);
	import fetch_pkg::*;

	// Fetch read request
	imem_read_t  rd;
	// Loader word write
	imem_write_t wr;

	////////////////////////////////////////////////////////////////////////////
	// Program counter
	////////////////////////////////////////////////////////////////////////////

	pc_sequencer u_pc_sequencer (
		.bus     (bus),
		.reset   (reset),
		.ctrl    (ctrl),
		.loading (loading),
		.rd      (rd)
	);

	// UART reprogramming path
	uart_word_loader u_uart_word_loader (
		.bus     (bus),
		.reset   (reset),
		.prog    (prog),
		.rx      (rx),
		.wr      (wr),
		.loading (loading)
	);

	// RAM and fetch register
	imem_controller u_imem_controller (
		.bus         (bus),
		.reset       (reset),
		.prog        (prog),
		.debug_index (debug_index),
		.wr          (wr),
		.rd          (rd),
		.fetched     (fetched)
	);

endmodule

// ==== verification/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;
	import fetch_pkg::*;

	logic                        bus;
	logic                        reset;
	fetch_ctrl_t                 ctrl;
	logic                        prog;
	logic [debug_addr_width-1:0] debug_index;
	logic                        rx;
	fetch_out_t                  fetched;
	logic                        loading;

	// Program image as written over the UART
	logic [word_width-1:0] shadow [32];
	logic [31:0]           lfsr_state;
	int                    errors;
	// Model of the fetch pipeline kept by the negedge checker
	logic                  track_en;
	logic                  pending;
	fetch_out_t            expected_out;
	logic [pc_width-1:0]   model_pc;

	fetch_reprogrammable_top u_fetch_reprogrammable_top (
		.bus         (bus),
		.reset       (reset),
		.ctrl        (ctrl),
		.prog        (prog),
		.debug_index (debug_index),
		.rx          (rx),
		.fetched     (fetched),
		.loading     (loading)
	);

	initial begin
		bus = 1'b0;
		forever #10 bus = ~bus;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Right shifting Galois LFSR
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// Expected next pc with jalr over branch over step
	function automatic logic [pc_width-1:0] next_pc_ref(input logic [pc_width-1:0] pc,
			input fetch_ctrl_t c);
		if (c.jalr) return c.branch_offset;
		if (c.branch) return pc + c.branch_offset;
		return pc + pc_width'(pc_step);
	endfunction

	function automatic fetch_ctrl_t make_ctrl(input logic en, input logic dbg,
			input logic br, input logic jr, input logic [pc_width-1:0] off);
		fetch_ctrl_t c;
		c.pc_en         = en;
		c.debug         = dbg;
		c.branch        = br;
		c.jalr          = jr;
		c.branch_offset = off;
		return c;
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Bounded wait on the loader level
	task automatic wait_loading(input logic level);
		int n;
		n = 0;
		while (loading !== level && n < 20) begin
			@(negedge bus);
			n++;
		end
		if (loading !== level) begin
			errors++;
			$display("Timeout: loading never went to %0b", level);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// UART stimulus
	////////////////////////////////////////////////////////////////////////////

	// 8N1 frame sent LSB first
	task automatic send_byte(input logic [7:0] b);
		@(posedge bus) rx <= 1'b0;
		repeat (clks_per_bit - 1) @(posedge bus);
		for (int i = 0; i < 8; i++) begin
			@(posedge bus) rx <= b[i];
			repeat (clks_per_bit - 1) @(posedge bus);
		end
		@(posedge bus) rx <= 1'b1;
		repeat (clks_per_bit - 1) @(posedge bus);
	endtask

	// Random 32 word image followed by debug read-back of every word
	task automatic load_program();
		logic [31:0] w;
		fetch_out_t  exp;
		@(posedge bus);
		track_en = 1'b0;
		prog <= 1'b1;
		wait_loading(1'b1);
		@(posedge bus) ctrl <= '0;
		for (int i = 0; i < 32; i++) begin
			rand_bits(32, w);
			shadow[i] = w;
			// Little endian byte order on the line
			for (int k = 0; k < 4; k++) send_byte(w[8*k +: 8]);
		end
		// Let the last write pulse land
		repeat (8) @(posedge bus);
		for (int i = 0; i < 32; i++) begin
			@(posedge bus) debug_index <= 5'(i);
			@(posedge bus);
			@(negedge bus);
			exp.pc  = pc_width'(i * 4);
			exp.ins = shadow[i];
			check_value(64'(fetched), 64'(exp), "debug read-back");
		end
		@(posedge bus) prog <= 1'b0;
		wait_loading(1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Fetch stimulus and checker
	////////////////////////////////////////////////////////////////////////////

	// Targets stay inside the 32 loaded words
	task automatic drive_random_cycle();
		logic [31:0]         r_en;
		logic [31:0]         r_dbg;
		logic [31:0]         r_kind;
		logic [31:0]         r_tgt;
		logic [pc_width-1:0] target;
		logic                br;
		logic                jr;
		@(posedge bus);
		rand_bits(2, r_en);
		rand_bits(3, r_dbg);
		rand_bits(2, r_kind);
		rand_bits(5, r_tgt);
		target = pc_width'({r_tgt[4:0], 2'b00});
		// Kind 0 jumps, kind 1 branches, kind 2 sets both, kind 3 steps
		jr = (r_kind[1:0] == 2'd0) || (r_kind[1:0] == 2'd2);
		br = (r_kind[1:0] == 2'd1) || (r_kind[1:0] == 2'd2);
		// A step from the last word would leave the image
		if (!jr && !br && model_pc >= pc_width'(124)) jr = 1'b1;
		ctrl <= make_ctrl(r_en[1:0] != 2'd0, r_dbg[2:0] == 3'd0, br, jr,
			jr ? target : target - model_pc);
	endtask

	task automatic run_fetch(input int seq_cycles, input int rand_cycles);
		@(posedge bus);
		ctrl <= '0;
		model_pc = '0;
		pending = 1'b0;
		track_en = 1'b1;
		// Straight line from address zero
		repeat (seq_cycles) @(posedge bus) ctrl <= make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, '0);
		// Stalls from pc_en low and then from debug
		repeat (4) @(posedge bus) ctrl <= make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, '0);
		repeat (4) @(posedge bus) ctrl <= make_ctrl(1'b1, 1'b1, 1'b0, 1'b0, '0);
		repeat (rand_cycles) drive_random_cycle();
	endtask

	// Negedge sampling sees the ctrl that the next edge takes
	always @(negedge bus) begin
		if (track_en) begin
			// Holds its value through stalls
			if (pending) check_value(64'(fetched), 64'(expected_out), "fetched item");
			if (ctrl.pc_en && !ctrl.debug) begin
				expected_out.pc  = model_pc;
				expected_out.ins = shadow[model_pc[pc_width-1:2]];
				pending = 1'b1;
				model_pc = next_pc_ref(model_pc, ctrl);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		ctrl = '0;
		prog = 1'b0;
		debug_index = '0;
		rx = 1'b1;
		lfsr_state = 32'h91740ca3;
		errors = 0;
		track_en = 1'b0;
		pending = 1'b0;
		expected_out = '0;
		model_pc = '0;
		repeat (5) @(posedge bus);
		reset <= 1'b0;
		@(negedge bus);
		check_value(64'(fetched), 64'd0, "fetched after reset");
		check_value(64'(loading), 64'd0, "loading after reset");
		load_program();
		run_fetch(24, 150);
		// Reprogram while the core is still running
		@(posedge bus) ctrl <= make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, '0);
		load_program();
		run_fetch(20, 100);
		@(posedge bus) ctrl <= '0;
		@(negedge bus);
		@(negedge bus);
		$display("Error count: %0d", errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
hw/fetch_pkg.sv
hw/pc_sequencer.sv
hw/uart_word_loader.sv
hw/imem_controller.sv
hw/fetch_reprogrammable_top.sv
verification/tb_fetch_top.sv
